// File: Makefile
# Verilator build for the APB byte mailbox
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mbox
RTL_TOP   ?= mbox_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_rtl sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulation binary is the pass/fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: apb_push_port.sv
// APB completer for the mailbox: register decode, FIFO push strobe and control state
module apb_push_port (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mbox_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [mbox_pkg::APB_DATA_W-1:0] pwdata,
    input  logic [mbox_pkg::CNT_W-1:0]      count,
    input  logic                            full,
    input  logic                            empty,
    output logic [mbox_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            push,
    output logic [mbox_pkg::DATA_W-1:0]     push_data,
    output logic                            drain_en
);
    import mbox_pkg::*;

    logic access;
    logic wr_access;
    logic rd_access;
    logic sel_data;
    logic sel_status;
    logic sel_ctrl;
    logic mapped;
    logic full_write;
    logic ovf;
    logic [APB_DATA_W-1:0] status_word;

    // No wait states
    assign pready = 1'b1;

    // Access phase of a transfer
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // Register decode
    assign sel_data   = (paddr == REG_DATA);
    assign sel_status = (paddr == REG_STATUS);
    assign sel_ctrl   = (paddr == REG_CTRL);
    assign mapped     = sel_data || sel_status || sel_ctrl;

    // Data writes that find no room are dropped
    assign full_write = wr_access && sel_data && full;
    assign push       = wr_access && sel_data && !full;
    assign push_data  = pwdata[DATA_W-1:0];

    assign pslverr = access && (!mapped || full_write);

    // Status word as it stands this cycle
    always_comb begin
        status_word = '0;
        status_word[STAT_CNT_LSB +: CNT_W] = count;
        status_word[STAT_EMPTY_BIT]        = empty;
        status_word[STAT_FULL_BIT]         = full;
        status_word[STAT_OVF_BIT]          = ovf;
    end

    // Read mux, data register reads as zero
    always_comb begin
        prdata = '0;
        if (rd_access && sel_status) begin
            prdata = status_word;
        end else if (rd_access && sel_ctrl) begin
            prdata[CTRL_DRAIN_BIT] = drain_en;
        end
    end

    // Drain enable from CTRL
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_en <= 1'b0;
        end else if (wr_access && sel_ctrl) begin
            drain_en <= pwdata[CTRL_DRAIN_BIT];
        end
    end

    // Sticky overflow
    // A fresh overflow wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ovf <= 1'b0;
        end else if (full_write) begin
            ovf <= 1'b1;
        end else if (wr_access && sel_ctrl && pwdata[CTRL_OVF_CLR_BIT]) begin
            ovf <= 1'b0;
        end
    end

    // Requester keeps psel up through the access phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("apb_push_port: penable without psel");

endmodule

// File: byte_fifo.sv
// Byte FIFO: circular store with wrapping pointers, occupancy count and full/empty flags
module byte_fifo #(
    parameter int DEPTH = mbox_pkg::FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [mbox_pkg::DATA_W-1:0] push_data,
    input  logic                        pop,
    output logic [mbox_pkg::DATA_W-1:0] head_data,
    output logic [mbox_pkg::CNT_W-1:0]  count,
    output logic                        full,
    output logic                        empty
);
    import mbox_pkg::*;

    // Storage, no reset on payload
    logic [DATA_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occ;

    // Advance a pointer, wrapping at DEPTH
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Synchronous write at the write pointer
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Oldest entry, read combinationally
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // Occupancy tracking
    // Push and pop together leave it unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occ <= '0;
        end else if (push && !pop) begin
            occ <= occ + 1'b1;
        end else if (pop && !push) begin
            occ <= occ - 1'b1;
        end
    end

    assign count = occ;
    assign full  = (occ == CNT_W'(DEPTH));
    assign empty = (occ == '0);

    // Producer must respect full unless a pop frees a slot this cycle
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        push && full |-> pop
    ) else $error("byte_fifo: push while full");

    // Consumer must never pop an empty FIFO
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        !(pop && empty)
    ) else $error("byte_fifo: pop while empty");

    // Occupancy stays within the store
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (rst)
        occ <= CNT_W'(DEPTH)
    ) else $error("byte_fifo: count above depth");

endmodule

// File: filelist.f
mbox_pkg.sv
byte_fifo.sv
apb_push_port.sv
stream_drain.sv
mbox_top.sv
tb_clock_gen.sv
tb_mbox.sv

// File: mbox_pkg.sv
// Mailbox package with payload widths, FIFO depth and the APB register map
package mbox_pkg;

    // Payload and buffer sizing
    localparam int DATA_W     = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    // One extra bit so a full FIFO count of 16 fits
    localparam int CNT_W      = PTR_W + 1;

    // APB completer widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Register byte offsets
    localparam logic [APB_ADDR_W-1:0] REG_DATA   = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h08;

    // Status word layout
    // Count sits in the low bits, flags start at bit 8
    localparam int STAT_CNT_LSB   = 0;
    localparam int STAT_EMPTY_BIT = 8;
    localparam int STAT_FULL_BIT  = 9;
    localparam int STAT_OVF_BIT   = 10;

    // Control word layout
    localparam int CTRL_DRAIN_BIT   = 0;
    localparam int CTRL_OVF_CLR_BIT = 1;

endpackage

// File: mbox_top.sv
// Mailbox top: APB push port, byte FIFO and stream drain engine
module mbox_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mbox_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [mbox_pkg::APB_DATA_W-1:0] pwdata,
    input  logic                            out_ready,
    output logic [mbox_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            out_valid,
    output logic [mbox_pkg::DATA_W-1:0]     out_data
);
    import mbox_pkg::*;

    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              pop;
    logic [DATA_W-1:0] head_data;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              empty;
    logic              drain_en;

    apb_push_port u_apb (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .count     (count),
        .full      (full),
        .empty     (empty),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data),
        .drain_en  (drain_en)
    );

    byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .count     (count),
        .full      (full),
        .empty     (empty)
    );

    stream_drain u_drain (
        .clk       (clk),
        .rst       (rst),
        .drain_en  (drain_en),
        .head_data (head_data),
        .empty     (empty),
        .out_ready (out_ready),
        .pop       (pop),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: stream_drain.sv
// Drain engine moving FIFO bytes into a registered valid/ready output stage
module stream_drain (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        drain_en,
    input  logic [mbox_pkg::DATA_W-1:0] head_data,
    input  logic                        empty,
    input  logic                        out_ready,
    output logic                        pop,
    output logic                        out_valid,
    output logic [mbox_pkg::DATA_W-1:0] out_data
);
    import mbox_pkg::*;

    logic stage_free;
    logic load;
    logic [DATA_W-1:0] stage_data;

    // Stage can take a byte when idle or handing one off now
    assign stage_free = !out_valid || out_ready;

    // Refill from the FIFO head
    assign load = drain_en && !empty && stage_free;
    assign pop  = load;

    // Valid flag of the output stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            // Byte left and nothing followed it
            out_valid <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (load) begin
            stage_data <= head_data;
        end
    end

    assign out_data = stage_data;

    // Held byte must not change under back-pressure
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("stream_drain: output changed while stalled");

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset generator, 10 ns clock with a five-cycle reset
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset drops just after the fifth rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: tb_mbox.sv
// Directed testbench for the APB byte mailbox with a stream sink and reference queue
module tb_mbox;
    timeunit 1ns;
    timeprecision 1ps;
    import mbox_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 200;
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_NS  = (NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    // Sink behavior for out_ready
    localparam int SINK_READY  = 0;
    localparam int SINK_STALL  = 1;
    localparam int SINK_RANDOM = 2;

    logic                  clk;
    logic                  rst;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic                  out_ready;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  out_valid;
    logic [DATA_W-1:0]     out_data;

    integer            seed;
    int                sink_mode;
    logic [DATA_W-1:0] model_q[$];
    logic [DATA_W-1:0] rx_q[$];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    mbox_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .out_ready (out_ready),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // Sink ready updates just after each rising edge
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            case (sink_mode)
                SINK_READY:  out_ready = 1'b1;
                SINK_STALL:  out_ready = 1'b0;
                default:     out_ready = 1'($random(seed));
            endcase
        end
    end

    // Capture the byte that transfers on the coming edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            rx_q.push_back(out_data);
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    // Setup cycle, access cycle, then idle
    // Responses are sampled mid access cycle
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic err);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check("pready", 32'(pready), 32'd1);
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check("pready", 32'(pready), 32'd1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Accepted bytes go into the reference queue
    task automatic write_byte(input logic [DATA_W-1:0] data, input logic exp_err);
        logic err;
        apb_write(REG_DATA, 32'(data), err);
        check("pslverr", 32'(err), 32'(exp_err));
        if (!err) begin
            model_q.push_back(data);
        end
    endtask

    task automatic set_ctrl(input logic drain, input logic ovf_clr);
        logic [APB_DATA_W-1:0] word;
        logic err;
        word = '0;
        word[CTRL_DRAIN_BIT]   = drain;
        word[CTRL_OVF_CLR_BIT] = ovf_clr;
        apb_write(REG_CTRL, word, err);
        check("pslverr", 32'(err), 32'd0);
    endtask

    task automatic check_status(input int exp_count, input logic exp_empty,
                                input logic exp_full, input logic exp_ovf);
        logic [APB_DATA_W-1:0] word;
        logic err;
        apb_read(REG_STATUS, word, err);
        check("pslverr", 32'(err), 32'd0);
        check("status.count", 32'(word[STAT_CNT_LSB +: CNT_W]), 32'(exp_count));
        check("status.empty", 32'(word[STAT_EMPTY_BIT]), 32'(exp_empty));
        check("status.full", 32'(word[STAT_FULL_BIT]), 32'(exp_full));
        check("status.overflow", 32'(word[STAT_OVF_BIT]), 32'(exp_ovf));
    endtask

    task automatic wait_rx(input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < TEST_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() < n) begin
            abort_run($sformatf("Stream delivered only %0d of %0d bytes", rx_q.size(), n));
        end
    endtask

    // A few spare cycles catch any extra byte
    task automatic compare_stream();
        repeat (4) @(posedge clk);
        check("received byte count", 32'(rx_q.size()), 32'(model_q.size()));
        while (model_q.size() > 0) begin
            check("out_data", 32'(rx_q.pop_front()), 32'(model_q.pop_front()));
        end
    endtask

    task automatic test_reset_state();
        check_status(0, 1'b1, 1'b0, 1'b0);
        check("out_valid", 32'(out_valid), 32'd0);
        check("received byte count", 32'(rx_q.size()), 32'd0);
    endtask

    task automatic test_ordered_delivery();
        sink_mode = SINK_READY;
        set_ctrl(1'b1, 1'b0);
        for (int i = 0; i < 10; i++) begin
            write_byte(8'h10 + 8'(i), 1'b0);
        end
        wait_rx(10);
        compare_stream();
        check_status(0, 1'b1, 1'b0, 1'b0);
    endtask

    // 16 in the FIFO plus one held in the output stage
    task automatic test_fill_overflow();
        sink_mode = SINK_STALL;
        for (int i = 0; i < 17; i++) begin
            write_byte(8'h40 + 8'(i), 1'b0);
        end
        check_status(FIFO_DEPTH, 1'b0, 1'b1, 1'b0);
        check("out_valid", 32'(out_valid), 32'd1);
        write_byte(8'hEE, 1'b1);
        check_status(FIFO_DEPTH, 1'b0, 1'b1, 1'b1);
        sink_mode = SINK_READY;
        wait_rx(17);
        compare_stream();
        check_status(0, 1'b1, 1'b0, 1'b1);
    endtask

    // Runs while overflow is still sticky from the fill test
    task automatic test_register_errors();
        logic [APB_DATA_W-1:0] rdata;
        logic err;
        apb_write(8'h0C, 32'hA5, err);
        check("pslverr", 32'(err), 32'd1);
        apb_read(8'h10, rdata, err);
        check("pslverr", 32'(err), 32'd1);
        apb_read(REG_DATA, rdata, err);
        check("pslverr", 32'(err), 32'd0);
        check("prdata", rdata, 32'd0);
        check_status(0, 1'b1, 1'b0, 1'b1);
        set_ctrl(1'b1, 1'b1);
        check_status(0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_drain_pause();
        sink_mode = SINK_READY;
        set_ctrl(1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            write_byte(8'h80 + 8'(i), 1'b0);
        end
        check_status(6, 1'b0, 1'b0, 1'b0);
        check("out_valid", 32'(out_valid), 32'd0);
        check("received byte count", 32'(rx_q.size()), 32'd0);
        set_ctrl(1'b1, 1'b0);
        wait_rx(6);
        compare_stream();
    endtask

    task automatic test_random_backpressure();
        sink_mode = SINK_RANDOM;
        for (int i = 0; i < 40; i++) begin
            write_byte(8'($random(seed)), 1'b0);
        end
        wait_rx(40);
        sink_mode = SINK_READY;
        compare_stream();
        check_status(0, 1'b1, 1'b0, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        seed       = 84509;
        sink_mode  = SINK_READY;
        @(posedge clk);
        wait (rst === 1'b0);
        test_reset_state();
        test_ordered_delivery();
        test_fill_overflow();
        test_register_errors();
        test_drain_pause();
        test_random_backpressure();
        $display("All checks passed");
        $finish;
    end

endmodule
